// File: logic/rvc_pkg.sv
package rvc_pkg;

    typedef logic [31:0] instr_t;

    typedef enum logic [1:0] {
        Q0      = 2'b00,
        Q1      = 2'b01,
        Q2      = 2'b10,
        Q3_FULL = 2'b11   // Not compressed
    } rvc_quadrant_e;

    typedef enum logic [2:0] {
        C0_ADDI4SPN = 3'b000,
        C0_LW       = 3'b010,
        C0_SW       = 3'b110
    } c0_funct3_e;

    typedef enum logic [2:0] {
        C1_ADDI         = 3'b000,
        C1_LI           = 3'b010,
        C1_ADDI16SP_LUI = 3'b011,
        C1_ALU          = 3'b100,
        C1_J            = 3'b101,
        C1_BEQZ         = 3'b110,
        C1_BNEZ         = 3'b111
    } c1_funct3_e;

    typedef enum logic [2:0] {
        C2_SLLI    = 3'b000,
        C2_LWSP    = 3'b010,
        C2_JR_GRP  = 3'b100,   // JR, MV, EBREAK, JALR, ADD
        C2_SWSP    = 3'b110
    } c2_funct3_e;

    typedef enum logic [1:0] {
        ALU_SRLI = 2'b00,
        ALU_SRAI = 2'b01,
        ALU_ANDI = 2'b10,
        ALU_REG  = 2'b11
    } c1_alu_e;

    typedef enum logic [1:0] {
        REGOP_SUB = 2'b00,
        REGOP_XOR = 2'b01,
        REGOP_OR  = 2'b10,
        REGOP_AND = 2'b11
    } c1_regop_e;

    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        LUI    = 7'b0110111,
        OP     = 7'b0110011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        SYSTEM = 7'b1110011
    } rv_opcode_e;

    localparam logic [4:0] REG_ZERO = 5'd0;
    localparam logic [4:0] REG_RA   = 5'd1;
    localparam logic [4:0] REG_SP   = 5'd2;

    localparam logic [1:0] CREG_PREFIX = 2'b01;   // x8..x15

    localparam instr_t EBREAK_INSTR = {12'h001, REG_ZERO, 3'b000, REG_ZERO, SYSTEM};

    typedef struct packed {
        instr_t instr;
        logic   illegal;
    } expand_t;

    typedef struct packed {
        instr_t instr;
        logic   is_compressed;
        logic   illegal;
    } dec_out_t;

endpackage

// File: logic/rvc_quadrant0.sv
`timescale 1ns/1ps

module rvc_quadrant0 (
    input  rvc_pkg::instr_t  i_instr,
    output rvc_pkg::expand_t o_res
);
    import rvc_pkg::*;

    c0_funct3_e  funct3;
    logic [4:0]  rd_p;
    logic [4:0]  rs1_p;
    logic [11:0] addi_imm;
    logic [11:0] word_off;

    assign funct3   = c0_funct3_e'(i_instr[15:13]);
    assign rd_p     = {CREG_PREFIX, i_instr[4:2]};
    assign rs1_p    = {CREG_PREFIX, i_instr[9:7]};
    // nzuimm[9:2], scaled by 4
    assign addi_imm = {2'b00, i_instr[10:7], i_instr[12:11], i_instr[5], i_instr[6], 2'b00};
    assign word_off = {5'b0, i_instr[5], i_instr[12:10], i_instr[6], 2'b00};

    always_comb begin
        o_res.instr   = i_instr;
        o_res.illegal = 1'b0;
        case (funct3)
            C0_ADDI4SPN: begin
                o_res.instr   = {addi_imm, REG_SP, 3'b000, rd_p, OP_IMM};
                o_res.illegal = (i_instr[12:5] == 8'b0);   // Zero imm reserved
            end
            C0_LW: begin
                o_res.instr = {word_off, rs1_p, 3'b010, rd_p, LOAD};
            end
            C0_SW: begin
                o_res.instr = {word_off[11:5], rd_p, rs1_p, 3'b010, word_off[4:0], STORE};
            end
            default: begin
                o_res.illegal = 1'b1;   // LD, SD, FP slots
            end
        endcase
    end

endmodule

// File: logic/rvc_quadrant1.sv
`timescale 1ns/1ps

module rvc_quadrant1 (
    input  rvc_pkg::instr_t  i_instr,
    output rvc_pkg::expand_t o_res
);
    import rvc_pkg::*;

    c1_funct3_e  funct3;
    c1_alu_e     alu_op;
    c1_regop_e   reg_op;
    logic [4:0]  rd;
    logic [4:0]  rs1_p;
    logic [4:0]  rs2_p;
    logic [11:0] imm6_sx;
    logic [11:0] sp16_imm;
    logic [19:0] lui_imm;
    logic [20:0] j_off;
    logic [12:0] b_off;
    logic        imm6_zero;

    assign funct3    = c1_funct3_e'(i_instr[15:13]);
    assign alu_op    = c1_alu_e'(i_instr[11:10]);
    assign reg_op    = c1_regop_e'(i_instr[6:5]);
    assign rd        = i_instr[11:7];
    assign rs1_p     = {CREG_PREFIX, i_instr[9:7]};
    assign rs2_p     = {CREG_PREFIX, i_instr[4:2]};
    assign imm6_sx   = {{6{i_instr[12]}}, i_instr[12], i_instr[6:2]};
    assign imm6_zero = ({i_instr[12], i_instr[6:2]} == 6'b0);
    assign sp16_imm  = {{3{i_instr[12]}}, i_instr[4:3], i_instr[5], i_instr[2], i_instr[6],
                        4'b0000};
    assign lui_imm   = {{15{i_instr[12]}}, i_instr[6:2]};
    // Sign-extended jump and branch offsets, bit 0 always zero
    assign j_off = {{10{i_instr[12]}}, i_instr[8], i_instr[10:9], i_instr[6], i_instr[7],
                    i_instr[2], i_instr[11], i_instr[5:3], 1'b0};
    assign b_off = {{5{i_instr[12]}}, i_instr[6:5], i_instr[2], i_instr[11:10],
                    i_instr[4:3], 1'b0};

    always_comb begin
        o_res.instr   = i_instr;
        o_res.illegal = 1'b0;
        case (funct3)
            C1_ADDI: begin
                o_res.instr = {imm6_sx, rd, 3'b000, rd, OP_IMM};   // Includes C.NOP
            end
            C1_LI: begin
                o_res.instr = {imm6_sx, REG_ZERO, 3'b000, rd, OP_IMM};
            end
            C1_ADDI16SP_LUI: begin
                if (rd == REG_SP) begin
                    o_res.instr = {sp16_imm, REG_SP, 3'b000, REG_SP, OP_IMM};
                end else begin
                    o_res.instr = {lui_imm, rd, LUI};
                end
                o_res.illegal = imm6_zero;
            end
            C1_ALU: begin
                case (alu_op)
                    ALU_SRLI: begin
                        o_res.instr   = {7'b0000000, i_instr[6:2], rs1_p, 3'b101, rs1_p, OP_IMM};
                        o_res.illegal = i_instr[12];   // shamt[5] not on RV32
                    end
                    ALU_SRAI: begin
                        o_res.instr   = {7'b0100000, i_instr[6:2], rs1_p, 3'b101, rs1_p, OP_IMM};
                        o_res.illegal = i_instr[12];
                    end
                    ALU_ANDI: begin
                        o_res.instr = {imm6_sx, rs1_p, 3'b111, rs1_p, OP_IMM};
                    end
                    default: begin
                        case (reg_op)
                            REGOP_SUB: o_res.instr = {7'b0100000, rs2_p, rs1_p, 3'b000, rs1_p, OP};
                            REGOP_XOR: o_res.instr = {7'b0000000, rs2_p, rs1_p, 3'b100, rs1_p, OP};
                            REGOP_OR:  o_res.instr = {7'b0000000, rs2_p, rs1_p, 3'b110, rs1_p, OP};
                            default:   o_res.instr = {7'b0000000, rs2_p, rs1_p, 3'b111, rs1_p, OP};
                        endcase
                        o_res.illegal = i_instr[12];   // SUBW, ADDW and reserved
                    end
                endcase
            end
            C1_J: begin
                o_res.instr = {j_off[20], j_off[10:1], j_off[11], j_off[19:12], REG_ZERO, JAL};
            end
            C1_BEQZ: begin
                o_res.instr = {b_off[12], b_off[10:5], REG_ZERO, rs1_p, 3'b000,
                               b_off[4:1], b_off[11], BRANCH};
            end
            C1_BNEZ: begin
                o_res.instr = {b_off[12], b_off[10:5], REG_ZERO, rs1_p, 3'b001,
                               b_off[4:1], b_off[11], BRANCH};
            end
            default: begin
                o_res.illegal = 1'b1;   // C.JAL / C.ADDIW slot
            end
        endcase
    end

endmodule

// File: logic/rvc_quadrant2.sv
`timescale 1ns/1ps

module rvc_quadrant2 (
    input  rvc_pkg::instr_t  i_instr,
    output rvc_pkg::expand_t o_res
);
    import rvc_pkg::*;

    c2_funct3_e  funct3;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [11:0] lwsp_off;
    logic [11:0] swsp_off;

    assign funct3   = c2_funct3_e'(i_instr[15:13]);
    assign rd       = i_instr[11:7];   // Also rs1 for JR/JALR
    assign rs2      = i_instr[6:2];
    assign lwsp_off = {4'b0, i_instr[3:2], i_instr[12], i_instr[6:4], 2'b00};
    assign swsp_off = {4'b0, i_instr[8:7], i_instr[12:9], 2'b00};

    always_comb begin
        o_res.instr   = i_instr;
        o_res.illegal = 1'b0;
        case (funct3)
            C2_SLLI: begin
                o_res.instr   = {7'b0000000, rs2, rd, 3'b001, rd, OP_IMM};
                o_res.illegal = i_instr[12];
            end
            C2_LWSP: begin
                o_res.instr   = {lwsp_off, REG_SP, 3'b010, rd, LOAD};
                o_res.illegal = (rd == REG_ZERO);
            end
            C2_JR_GRP: begin
                if (!i_instr[12]) begin
                    if (rs2 == REG_ZERO) begin
                        o_res.instr   = {12'b0, rd, 3'b000, REG_ZERO, JALR};
                        o_res.illegal = (rd == REG_ZERO);   // JR x0 reserved
                    end else begin
                        o_res.instr = {7'b0000000, rs2, REG_ZERO, 3'b000, rd, OP};   // MV
                    end
                end else if (rs2 == REG_ZERO && rd == REG_ZERO) begin
                    o_res.instr = EBREAK_INSTR;
                end else if (rs2 == REG_ZERO) begin
                    o_res.instr = {12'b0, rd, 3'b000, REG_RA, JALR};
                end else begin
                    o_res.instr = {7'b0000000, rs2, rd, 3'b000, rd, OP};   // ADD
                end
            end
            C2_SWSP: begin
                o_res.instr = {swsp_off[11:5], rs2, REG_SP, 3'b010, swsp_off[4:0], STORE};
            end
            default: begin
                o_res.illegal = 1'b1;   // FP and RV64 stack forms
            end
        endcase
    end

endmodule

// File: logic/rvc_output_stage.sv
`timescale 1ns/1ps

module rvc_output_stage (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_valid,
    input  rvc_pkg::instr_t   i_instr,
    input  rvc_pkg::expand_t  i_q0_res,
    input  rvc_pkg::expand_t  i_q1_res,
    input  rvc_pkg::expand_t  i_q2_res,
    output logic              o_valid,
    output rvc_pkg::dec_out_t o_dec
);
    import rvc_pkg::*;

    rvc_quadrant_e quad;
    expand_t       sel_res;
    dec_out_t      dec_next;

    assign quad = rvc_quadrant_e'(i_instr[1:0]);

    always_comb begin
        case (quad)
            Q0:      sel_res = i_q0_res;
            Q1:      sel_res = i_q1_res;
            Q2:      sel_res = i_q2_res;
            default: sel_res = '{instr: i_instr, illegal: 1'b0};
        endcase
    end

    always_comb begin
        if (i_instr == '0 || quad == Q3_FULL) begin
            dec_next = '{instr: i_instr, is_compressed: 1'b0, illegal: 1'b0};
        end else if (sel_res.illegal) begin
            dec_next = '{instr: i_instr, is_compressed: 1'b1, illegal: 1'b1};   // Raw word back
        end else begin
            dec_next = '{instr: sel_res.instr, is_compressed: 1'b1, illegal: 1'b0};
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
            o_dec   <= '0;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin
                o_dec <= dec_next;   // Held while idle
            end
        end
    end

    // Every legal expansion is a full-width base instruction
    a_expanded_opcode: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_valid && o_dec.is_compressed && !o_dec.illegal) |-> (o_dec.instr[1:0] == 2'b11));

    a_valid_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $past(i_rst_n) |-> (o_valid == $past(i_valid)));

endmodule

// File: logic/rvc_expander.sv
`timescale 1ns/1ps

module rvc_expander (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_valid,
    input  rvc_pkg::instr_t   i_instr,
    output logic              o_valid,
    output rvc_pkg::dec_out_t o_dec
);
    import rvc_pkg::*;

    expand_t q0_res;
    expand_t q1_res;
    expand_t q2_res;

    rvc_quadrant0 u_quadrant0 (
        .i_instr (i_instr),
        .o_res   (q0_res)
    );

    rvc_quadrant1 u_quadrant1 (
        .i_instr (i_instr),
        .o_res   (q1_res)
    );

    rvc_quadrant2 u_quadrant2 (
        .i_instr (i_instr),
        .o_res   (q2_res)
    );

    rvc_output_stage u_output_stage (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_valid  (i_valid),
        .i_instr  (i_instr),
        .i_q0_res (q0_res),
        .i_q1_res (q1_res),
        .i_q2_res (q2_res),
        .o_valid  (o_valid),
        .o_dec    (o_dec)
    );

endmodule

// File: tb/tb_rvc_expander.sv
`timescale 1ns/1ps

module tb_rvc_expander;
    import rvc_pkg::*;

    localparam int NUM_PAT    = 33;
    localparam int NUM_RAND   = 200;
    localparam int RST_CYCLES = 16;
    // Random phase idles every other group of three cycles
    localparam int MAX_CYCLES = RST_CYCLES + NUM_PAT + 2 * NUM_RAND + 20;

    logic     clk;
    logic     rst_n;
    logic     valid;
    instr_t   instr;
    logic     out_valid;
    dec_out_t out_dec;

    logic [31:0] pat_mem [0:4*NUM_PAT-1];   // word, expansion, compressed, illegal
    logic        exp_valid;
    dec_out_t    exp_dec;
    int          mismatches;
    int          failures;
    int          cycle_count = 0;

    rvc_expander dut (
        .i_clk   (clk),
        .i_rst_n (rst_n),
        .i_valid (valid),
        .i_instr (instr),
        .o_valid (out_valid),
        .o_dec   (out_dec)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors: mismatches=%0d other=%0d", mismatches, failures + 1);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic dec_out_t make_result(input instr_t word, input logic comp,
                                             input logic ill);
        dec_out_t r;
        r.instr         = word;
        r.is_compressed = comp;
        r.illegal       = ill;
        return r;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expv,
                                   input logic [31:0] actv);
        $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, expv, actv);
        mismatches++;
    endtask

    task automatic check_outputs();
        if (out_valid !== exp_valid) begin
            report_mismatch("o_valid", 32'(exp_valid), 32'(out_valid));
        end
        if (out_dec.instr !== exp_dec.instr) begin
            report_mismatch("o_dec.instr", exp_dec.instr, out_dec.instr);
        end
        if (out_dec.is_compressed !== exp_dec.is_compressed) begin
            report_mismatch("o_dec.is_compressed", 32'(exp_dec.is_compressed),
                            32'(out_dec.is_compressed));
        end
        if (out_dec.illegal !== exp_dec.illegal) begin
            report_mismatch("o_dec.illegal", 32'(exp_dec.illegal), 32'(out_dec.illegal));
        end
    endtask

    // Checks last cycle's result, then drives the next word
    task automatic step(input logic valid_in, input instr_t word, input dec_out_t expd);
        @(posedge clk);
        #1;
        check_outputs();
        valid     = valid_in;
        instr     = word;
        exp_valid = valid_in;
        if (valid_in) begin
            exp_dec = expd;   // Output holds while idle
        end
    endtask

    initial begin
        int          k;
        int          sent;
        logic [31:0] seed;
        instr_t      word;
        clk        = 1'b0;
        rst_n      = 1'b0;
        valid      = 1'b0;
        instr      = '0;
        exp_valid  = 1'b0;
        exp_dec    = '0;
        mismatches = 0;
        failures   = 0;
        for (k = 0; k < 4 * NUM_PAT; k++) begin
            pat_mem[k] = 32'hA5A50000 ^ 32'(k);
        end
        $readmemh("tb/rvc_patterns.hex", pat_mem);
        for (k = 0; k < NUM_PAT; k++) begin
            if (pat_mem[4*k+2] > 1 || pat_mem[4*k+3] > 1) begin
                $display("Pattern record %0d was not loaded or has a bad flag", k);
                failures++;
            end
        end

        repeat (RST_CYCLES) begin
            @(posedge clk);
            #1;
            check_outputs();
        end
        rst_n = 1'b1;

        for (k = 0; k < NUM_PAT; k++) begin
            step(1'b1, pat_mem[4*k], make_result(pat_mem[4*k+1], pat_mem[4*k+2][0],
                                                 pat_mem[4*k+3][0]));
        end

        // Uncompressed words, valid high three cycles then low three
        seed = 32'd6048;
        sent = 0;
        k    = 0;
        while (sent < NUM_RAND) begin
            seed = lcg_next(seed);
            word = seed | 32'h3;
            if (((k / 3) % 2) == 0) begin
                step(1'b1, word, make_result(word, 1'b0, 1'b0));
                sent++;
            end else begin
                step(1'b0, word, exp_dec);
            end
            k++;
        end
        step(1'b0, '0, exp_dec);
        step(1'b0, '0, exp_dec);

        $display("Errors: mismatches=%0d other=%0d", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tb/rvc_patterns.hex
// input_word expected_instr is_compressed illegal
// Illegal forms expect the input word back unchanged
00000800 01010413 1 0 // C.ADDI4SPN x8, 16
00004144 00452483 1 0 // C.LW x9, 4(x10)
0000C144 00952223 1 0 // C.SW x9, 4(x10)
000010FD FFF08093 1 0 // C.ADDI x1, -1
0000428D 00300293 1 0 // C.LI x5, 3
00006105 02010113 1 0 // C.ADDI16SP 32
00006285 000012B7 1 0 // C.LUI x5, 1
0000800D 00345413 1 0 // C.SRLI x8, 3
0000840D 40345413 1 0 // C.SRAI x8, 3
00008815 00547413 1 0 // C.ANDI x8, 5
00008C05 40940433 1 0 // C.SUB x8, x9
00008C25 00944433 1 0 // C.XOR x8, x9
00008C45 00946433 1 0 // C.OR x8, x9
00008C65 00947433 1 0 // C.AND x8, x9
0000A021 0080006F 1 0 // C.J +8
0000C401 00040463 1 0 // C.BEQZ x8, +8
0000E401 00041463 1 0 // C.BNEZ x8, +8
0000028E 00329293 1 0 // C.SLLI x5, 3
00004292 00412283 1 0 // C.LWSP x5, 4
00008282 00028067 1 0 // C.JR x5
0000829A 006002B3 1 0 // C.MV x5, x6
00009002 00100073 1 0 // C.EBREAK
00009282 000280E7 1 0 // C.JALR x5
0000929A 006282B3 1 0 // C.ADD x5, x6
0000C21A 00612223 1 0 // C.SWSP x6, 4
00006144 00006144 1 1 // C.LD
00000004 00000004 1 1 // C.ADDI4SPN zero imm
00002085 00002085 1 1 // C.ADDIW
00009C05 00009C05 1 1 // C.SUBW
00008002 00008002 1 1 // C.JR x0
0000128E 0000128E 1 1 // C.SLLI shamt[5] set
00000000 00000000 0 0 // All-zero word
00A00093 00A00093 0 0 // Uncompressed addi

// File: sim.f
logic/rvc_pkg.sv
logic/rvc_quadrant0.sv
logic/rvc_quadrant1.sv
logic/rvc_quadrant2.sv
logic/rvc_output_stage.sv
logic/rvc_expander.sv
tb/tb_rvc_expander.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f sim.f --top-module tb_rvc_expander -o tb_rvc_expander
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_rvc_expander > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Test completed successfully$" sim.log; then
    exit 0
fi
exit 1
